//--- soc_pkg.sv
package soc_pkg;

	// ------------------------------------------------------------------------
	// bus types
	// ------------------------------------------------------------------------

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	// all strobes low means a read
	typedef logic [3:0] strb_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		data_t rdata;
		logic  ready;
	} bus_rsp_t;

	// top address nibble
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2,
		REGION_RAM  = 4'h4
	} region_e;

	// misc register index, address bits 6:2
	typedef enum logic [4:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FSEL      = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21,
		REG_PMOD_IN   = 5'd22,
		REG_PMOD_OUT  = 5'd23,
		REG_PMOD_OE   = 5'd24,
		REG_PMOD_W2S  = 5'd25,
		REG_PMOD_W2C  = 5'd26
	} misc_reg_e;

	// ------------------------------------------------------------------------
	// gpio and board i/o
	// ------------------------------------------------------------------------

	// order follows the OUT, OE, W2S, W2C register order of each bank
	typedef enum logic [1:0] {
		GPIO_OUT = 2'd0,
		GPIO_OE  = 2'd1,
		GPIO_SET = 2'd2,
		GPIO_CLR = 2'd3
	} gpio_op_e;

	typedef struct packed {
		logic     we;
		gpio_op_e op;
		data_t    wdata;
	} gpio_cmd_t;

	typedef logic [29:0] genio_pins_t;
	typedef logic [7:0]  pmod_pins_t;
	typedef logic [15:0] led_t;
	typedef logic [7:0]  btn_t;

	// constants
	localparam data_t       SOC_VERSION       = 32'h0000_0001;
	localparam data_t       BUS_ERROR_WORD    = 32'hDEAD_BEEF;
	localparam int          IRQ_BUS_ERROR     = 3;
	// upper 24 bits of an fsel write that request an fpga reload
	localparam logic [23:0] FSEL_KEY          = 24'hD0F1A5;
	localparam int          RAM_WORDS_DEFAULT = 1024;

endpackage

//--- bus_ctrl.sv
`timescale 1ns/100ps

module bus_ctrl import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        bus_valid_i,
	input  bus_req_t    bus_req_i,
	output bus_rsp_t    bus_rsp_o,
	output data_t       irq_o,
	input  btn_t        btn_i,
	output led_t        led_o,
	input  genio_pins_t genio_in_i,
	input  genio_pins_t genio_out_i,
	input  genio_pins_t genio_oe_i,
	output gpio_cmd_t   genio_cmd_o,
	input  pmod_pins_t  pmod_in_i,
	input  pmod_pins_t  pmod_out_i,
	input  pmod_pins_t  pmod_oe_i,
	output gpio_cmd_t   pmod_cmd_o,
	output logic        ram_sel_o,
	output bus_req_t    ram_req_o,
	input  data_t       ram_rdata_i,
	input  logic        ram_ready_i,
	output logic        fsel_we_o,
	output data_t       fsel_wdata_o,
	input  logic        fsel_d_i
);

	region_e   region;
	misc_reg_e reg_idx;
	logic      misc_sel;
	logic      bus_err;
	logic      misc_wr;
	logic [4:0] genio_off;
	logic [4:0] pmod_off;
	led_t      led_q;
	data_t     rdata;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------

	assign region  = region_e'(bus_req_i.addr[31:28]);
	assign reg_idx = misc_reg_e'(bus_req_i.addr[6:2]);

	assign misc_sel  = bus_valid_i && (region == REGION_MISC);
	assign ram_sel_o = bus_valid_i && (region == REGION_RAM);
	assign bus_err   = bus_valid_i && (region != REGION_MISC) && (region != REGION_RAM);
	// misc accesses complete in the cycle they are presented
	assign misc_wr   = misc_sel && (bus_req_i.wstrb != '0);

	assign ram_req_o = bus_req_i;

	// gpio commands, register offset within a bank picks the operation
	assign genio_off = reg_idx - REG_GENIO_OUT;
	assign pmod_off  = reg_idx - REG_PMOD_OUT;

	assign genio_cmd_o.we    = misc_wr && (reg_idx inside {[REG_GENIO_OUT:REG_GENIO_W2C]});
	assign genio_cmd_o.op    = gpio_op_e'(genio_off[1:0]);
	assign genio_cmd_o.wdata = bus_req_i.wdata;
	assign pmod_cmd_o.we     = misc_wr && (reg_idx inside {[REG_PMOD_OUT:REG_PMOD_W2C]});
	assign pmod_cmd_o.op     = gpio_op_e'(pmod_off[1:0]);
	assign pmod_cmd_o.wdata  = bus_req_i.wdata;

	assign fsel_we_o    = misc_wr && (reg_idx == REG_FSEL);
	assign fsel_wdata_o = bus_req_i.wdata;

	// led register
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q <= '0;
		end else if (misc_wr && (reg_idx == REG_LED)) begin
			led_q <= bus_req_i.wdata[15:0];
		end
	end

	assign led_o = led_q;

	// ------------------------------------------------------------------------
	// read data, ready and interrupts
	// ------------------------------------------------------------------------

	always_comb begin
		rdata = '0;
		if (region == REGION_MISC) begin
			case (reg_idx)
				REG_LED:       rdata = {16'h0, led_q};
				REG_BTN:       rdata = {24'h0, ~btn_i};
				REG_SOC_VER:   rdata = SOC_VERSION;
				REG_FSEL:      rdata = {31'h0, fsel_d_i};
				REG_GENIO_IN:  rdata = {2'h0, genio_in_i};
				REG_GENIO_OUT: rdata = {2'h0, genio_out_i};
				REG_GENIO_OE:  rdata = {2'h0, genio_oe_i};
				REG_PMOD_IN:   rdata = {24'h0, pmod_in_i};
				REG_PMOD_OUT:  rdata = {24'h0, pmod_out_i};
				REG_PMOD_OE:   rdata = {24'h0, pmod_oe_i};
				default:       rdata = '0;
			endcase
		end else if (region == REGION_RAM) begin
			rdata = ram_rdata_i;
		end else begin
			rdata = BUS_ERROR_WORD;
		end
	end

	assign bus_rsp_o.rdata = rdata;
	assign bus_rsp_o.ready = misc_sel || bus_err || ram_ready_i;

	always_comb begin
		irq_o = '0;
		irq_o[IRQ_BUS_ERROR] = bus_err;
	end

	// the ram may only answer an access that is still being presented
	assert property (@(posedge clk48m) disable iff (rst) $rose(ram_ready_i) |-> ram_sel_o);
	assert property (@(posedge clk48m) disable iff (rst) (irq_o != '0) |-> bus_valid_i);

endmodule

//--- gpio_bank.sv
`timescale 1ns/100ps

module gpio_bank import soc_pkg::*; #(
	parameter type pin_t = genio_pins_t
) (
	input  logic      clk48m,
	input  logic      rst,
	input  gpio_cmd_t cmd_i,
	output pin_t      out_o,
	output pin_t      oe_o
);

	localparam int W = $bits(pin_t);

	pin_t out_q;
	pin_t oe_q;
	pin_t wbits;

	// only the low bits of the bus word reach the pins
	assign wbits = cmd_i.wdata[W-1:0];

	// ------------------------------------------------------------------------
	// output and output-enable registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (cmd_i.we) begin
			case (cmd_i.op)
				GPIO_OUT: begin
					out_q <= wbits;
				end
				GPIO_OE: begin
					oe_q <= wbits;
				end
				GPIO_SET: begin
					out_q <= out_q | wbits;
				end
				GPIO_CLR: begin
					// a one in the written word clears that pin
					out_q <= out_q & ~wbits;
				end
				default: begin
					out_q <= out_q;
				end
			endcase
		end
	end

	assign out_o = out_q;
	assign oe_o  = oe_q;

endmodule

//--- scratch_ram.sv
`timescale 1ns/100ps

module scratch_ram import soc_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
	input  logic     clk48m,
	input  logic     rst,
	input  logic     sel_i,
	input  bus_req_t req_i,
	output data_t    rdata_o,
	output logic     ready_o
);

	localparam int AW = $clog2(RAM_WORDS);

	data_t         mem [RAM_WORDS];
	logic [AW-1:0] word_idx;
	logic          ready_q;
	data_t         rdata_q;

	assign word_idx = AW'(req_i.addr[31:2] % RAM_WORDS);

	// one stall cycle per access, ready drops again right after
	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= sel_i && !ready_q;
		end
	end

	always_ff @(posedge clk48m) begin
		if (sel_i && !ready_q) begin
			rdata_q <= mem[word_idx];
		end
		// writes commit on the edge that completes the access
		if (sel_i && ready_q) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.wstrb[b]) begin
					mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
				end
			end
		end
	end

	assign rdata_o = rdata_q;
	assign ready_o = ready_q;

	assert property (@(posedge clk48m) disable iff (rst) ready_o |=> !ready_o);

endmodule

//--- reload_seq.sv
`timescale 1ns/100ps

module reload_seq import soc_pkg::*; (
	input  logic  clk48m,
	input  logic  rst,
	input  logic  fsel_we_i,
	input  data_t wdata_i,
	output logic  fsel_d_o,
	output logic  fsel_c_o,
	output logic  programn_o
);

	logic       fsel_d_q;
	logic       strobe_q;
	logic       reload_queued_q;
	logic       reload_q;
	logic [2:0] delay_q;

	// flash select bit, write strobe and pending reload request
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d_q        <= 1'b0;
			strobe_q        <= 1'b0;
			reload_queued_q <= 1'b0;
		end else begin
			strobe_q <= fsel_we_i;
			if (fsel_we_i) begin
				fsel_d_q <= wdata_i[0];
				if (wdata_i[31:8] == FSEL_KEY) begin
					reload_queued_q <= 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// delay counter, gives the select flop time before programn is pulled
	// ------------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			delay_q  <= '0;
			reload_q <= 1'b0;
		end else if (strobe_q) begin
			delay_q <= 3'd7;
		end else if (delay_q != 3'd0) begin
			delay_q <= delay_q - 3'd1;
			if ((delay_q == 3'd1) && reload_queued_q) begin
				reload_q <= 1'b1;
			end
		end
	end

	assign fsel_d_o   = fsel_d_q;
	assign fsel_c_o   = (delay_q == 3'd5) || (delay_q == 3'd4) || (delay_q == 3'd3);
	assign programn_o = ~reload_q;

	assert property (@(posedge clk48m) (!programn_o && !rst) |=> !programn_o);

endmodule

//--- soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top import soc_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        bus_valid_i,
	input  bus_req_t    bus_req_i,
	output bus_rsp_t    bus_rsp_o,
	output data_t       irq_o,
	input  btn_t        btn_i,
	output led_t        led_o,
	input  genio_pins_t genio_in_i,
	output genio_pins_t genio_out_o,
	output genio_pins_t genio_oe_o,
	input  pmod_pins_t  pmod_in_i,
	output pmod_pins_t  pmod_out_o,
	output pmod_pins_t  pmod_oe_o,
	output logic        fsel_d_o,
	output logic        fsel_c_o,
	output logic        programn_o
);

	gpio_cmd_t genio_cmd;
	gpio_cmd_t pmod_cmd;
	logic      ram_sel;
	bus_req_t  ram_req;
	data_t     ram_rdata;
	logic      ram_ready;
	logic      fsel_we;
	data_t     fsel_wdata;

	bus_ctrl u_bus_ctrl (
		.clk48m       (clk48m),
		.rst          (rst),
		.bus_valid_i  (bus_valid_i),
		.bus_req_i    (bus_req_i),
		.bus_rsp_o    (bus_rsp_o),
		.irq_o        (irq_o),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.genio_in_i   (genio_in_i),
		.genio_out_i  (genio_out_o),
		.genio_oe_i   (genio_oe_o),
		.genio_cmd_o  (genio_cmd),
		.pmod_in_i    (pmod_in_i),
		.pmod_out_i   (pmod_out_o),
		.pmod_oe_i    (pmod_oe_o),
		.pmod_cmd_o   (pmod_cmd),
		.ram_sel_o    (ram_sel),
		.ram_req_o    (ram_req),
		.ram_rdata_i  (ram_rdata),
		.ram_ready_i  (ram_ready),
		.fsel_we_o    (fsel_we),
		.fsel_wdata_o (fsel_wdata),
		.fsel_d_i     (fsel_d_o)
	);

	// one bank per pin group
	gpio_bank #(.pin_t(genio_pins_t)) u_genio (
		.clk48m (clk48m),
		.rst    (rst),
		.cmd_i  (genio_cmd),
		.out_o  (genio_out_o),
		.oe_o   (genio_oe_o)
	);

	gpio_bank #(.pin_t(pmod_pins_t)) u_pmod (
		.clk48m (clk48m),
		.rst    (rst),
		.cmd_i  (pmod_cmd),
		.out_o  (pmod_out_o),
		.oe_o   (pmod_oe_o)
	);

	scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
		.clk48m  (clk48m),
		.rst     (rst),
		.sel_i   (ram_sel),
		.req_i   (ram_req),
		.rdata_o (ram_rdata),
		.ready_o (ram_ready)
	);

	reload_seq u_reload (
		.clk48m     (clk48m),
		.rst        (rst),
		.fsel_we_i  (fsel_we),
		.wdata_i    (fsel_wdata),
		.fsel_d_o   (fsel_d_o),
		.fsel_c_o   (fsel_c_o),
		.programn_o (programn_o)
	);

endmodule

//--- tb_soc_bus_table.svh
localparam int N_ENTRIES = 14;

entry_t table_mem [N_ENTRIES];

task automatic fill_table();
	// is_write, addr, wdata, wstrb, expected rdata, expected irq bit
	table_mem[0]  = '{1'b1, 32'h2000_0000, {16'h0, LED_VALUE}, 4'hF, 32'h0, 1'b0};
	table_mem[1]  = '{1'b0, 32'h2000_0000, 32'h0, 4'h0, {16'h0, LED_VALUE}, 1'b0};
	table_mem[2]  = '{1'b0, 32'h2000_0008, 32'h0, 4'h0, 32'h0000_0001, 1'b0};
	table_mem[3]  = '{1'b0, 32'h2000_0004, 32'h0, 4'h0, {24'h0, ~BTN_VALUE}, 1'b0};
	// scratch ram, second write only touches bytes 0 and 2
	table_mem[4]  = '{1'b1, 32'h4000_0010, 32'h1122_3344, 4'hF, 32'h0, 1'b0};
	table_mem[5]  = '{1'b1, 32'h4000_0010, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0};
	table_mem[6]  = '{1'b1, 32'h4000_0020, 32'h5566_7788, 4'hF, 32'h0, 1'b0};
	table_mem[7]  = '{1'b0, 32'h4000_0010, 32'h0, 4'h0, 32'h11BB_33DD, 1'b0};
	table_mem[8]  = '{1'b0, 32'h4000_0020, 32'h0, 4'h0, 32'h5566_7788, 1'b0};
	// unmapped regions
	table_mem[9]  = '{1'b0, 32'h0000_0040, 32'h0, 4'h0, 32'hDEAD_BEEF, 1'b1};
	table_mem[10] = '{1'b1, 32'hF000_0000, 32'h1234_5678, 4'hF, 32'h0, 1'b1};
	table_mem[11] = '{1'b0, 32'hF000_0100, 32'h0, 4'h0, 32'hDEAD_BEEF, 1'b1};
	// unmapped misc register
	table_mem[12] = '{1'b0, 32'h2000_0014, 32'h0, 4'h0, 32'h0, 1'b0};
	table_mem[13] = '{1'b0, 32'h2000_0000, 32'h0, 4'h0, {16'h0, LED_VALUE}, 1'b0};
endtask

//--- tb_soc_bus.sv
`timescale 1ns/100ps

module tb_soc_bus import soc_pkg::*;;

	localparam int   PERIOD    = 100;
	localparam led_t LED_VALUE = 16'hA5C3;
	localparam btn_t BTN_VALUE = 8'h3C;

	typedef struct packed {
		logic  is_write;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
		data_t exp_rdata;
		logic  exp_irq;
	} entry_t;

	`include "tb_soc_bus_table.svh"

	// bus accesses of both gpio bank tests
	localparam int GPIO_STEPS    = 18;
	localparam int RELOAD_CYCLES = 12;
	localparam int TEST_STEPS    = N_ENTRIES + GPIO_STEPS + 2 * (RELOAD_CYCLES + 2);
	localparam int WATCHDOG_NS   = (8 + TEST_STEPS) * 20 * PERIOD;

	logic        clk48m;
	logic        rst;
	logic        bus_valid_i;
	bus_req_t    bus_req_i;
	bus_rsp_t    bus_rsp_o;
	data_t       irq_o;
	btn_t        btn_i;
	led_t        led_o;
	genio_pins_t genio_in_i;
	genio_pins_t genio_out_o;
	genio_pins_t genio_oe_o;
	pmod_pins_t  pmod_in_i;
	pmod_pins_t  pmod_out_o;
	pmod_pins_t  pmod_oe_o;
	logic        fsel_d_o;
	logic        fsel_c_o;
	logic        programn_o;

	int          checks;
	int          errors;
	logic [31:0] rng_state;
	data_t       rd;
	logic        irq_bit;

	soc_bus_top #(.RAM_WORDS(RAM_WORDS_DEFAULT)) UUT (
		.clk48m      (clk48m),
		.rst         (rst),
		.bus_valid_i (bus_valid_i),
		.bus_req_i   (bus_req_i),
		.bus_rsp_o   (bus_rsp_o),
		.irq_o       (irq_o),
		.btn_i       (btn_i),
		.led_o       (led_o),
		.genio_in_i  (genio_in_i),
		.genio_out_o (genio_out_o),
		.genio_oe_o  (genio_oe_o),
		.pmod_in_i   (pmod_in_i),
		.pmod_out_o  (pmod_out_o),
		.pmod_oe_o   (pmod_oe_o),
		.fsel_d_o    (fsel_d_o),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o)
	);

	initial begin
		clk48m = 1'b0;
	end

	always #(PERIOD / 2) clk48m = ~clk48m;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic addr_t misc_addr(input int idx);
		return 32'h2000_0000 | (addr_t'(idx) << 2);
	endfunction

	function automatic data_t out_pins(input int bank);
		return (bank == 0) ? {2'b00, genio_out_o} : {24'h0, pmod_out_o};
	endfunction

	function automatic data_t oe_pins(input int bank);
		return (bank == 0) ? {2'b00, genio_oe_o} : {24'h0, pmod_oe_o};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// drive on the falling edge and sample a quarter period before the rising edge
	task automatic bus_access(input entry_t e, output data_t rdata, output logic irq_b);
		int wait_cycles;
		int exp_wait;
		wait_cycles = 0;
		// ram answers one cycle late and everything else at once
		exp_wait = (e.addr[31:28] == 4'h4) ? 1 : 0;
		@(negedge clk48m);
		bus_valid_i = 1'b1;
		bus_req_i   = '{e.addr, e.wdata, e.wstrb};
		#(PERIOD / 4);
		while (!bus_rsp_o.ready) begin
			@(negedge clk48m);
			#(PERIOD / 4);
			wait_cycles++;
		end
		rdata = bus_rsp_o.rdata;
		irq_b = irq_o[3];
		check_value("ready latency", 32'(wait_cycles), 32'(exp_wait));
		@(negedge clk48m);
		bus_valid_i = 1'b0;
		bus_req_i   = '0;
		#(PERIOD / 4);
		check_value("irq_o after access", irq_o, 32'h0);
	endtask

	task automatic bus_write(input addr_t addr, input data_t data);
		entry_t e;
		data_t  dummy;
		logic   irq_b;
		e = '{1'b1, addr, data, 4'hF, 32'h0, 1'b0};
		bus_access(e, dummy, irq_b);
	endtask

	task automatic bus_read(input addr_t addr, output data_t data);
		entry_t e;
		logic   irq_b;
		e = '{1'b0, addr, 32'h0, 4'h0, 32'h0, 1'b0};
		bus_access(e, data, irq_b);
	endtask

	// out is loaded, then set and cleared with random patterns
	task automatic gpio_bank_test(input int bank);
		int    base;
		data_t mask;
		data_t model;
		data_t pattern;
		data_t rdata;
		string name;
		base = (bank == 0) ? int'(REG_GENIO_OUT) : int'(REG_PMOD_OUT);
		mask = (bank == 0) ? 32'h3FFF_FFFF : 32'h0000_00FF;
		name = (bank == 0) ? "genio" : "pmod";
		model = 32'h0;
		rng_state = xorshift32(rng_state);
		@(negedge clk48m);
		if (bank == 0) begin
			genio_in_i = rng_state[29:0];
		end else begin
			pmod_in_i = rng_state[7:0];
		end
		bus_read(misc_addr(base - 1), rdata);
		check_value({name, " in readback"}, rdata, rng_state & mask);
		for (int op = 0; op < 4; op++) begin
			rng_state = xorshift32(rng_state);
			pattern = rng_state;
			bus_write(misc_addr(base + op), pattern);
			if (op == 1) begin
				bus_read(misc_addr(base + 1), rdata);
				check_value({name, " oe readback"}, rdata, pattern & mask);
				check_value({name, " oe pins"}, oe_pins(bank), pattern & mask);
			end else begin
				if (op == 0) begin
					model = pattern & mask;
				end else if (op == 2) begin
					model = model | (pattern & mask);
				end else begin
					model = model & ~pattern;
				end
				bus_read(misc_addr(base), rdata);
				check_value({name, " out readback"}, rdata, model);
				check_value({name, " out pins"}, out_pins(bank), model);
			end
		end
	endtask

	// samples once per cycle after the write edge
	task automatic fsel_write_check(input data_t wdata, input logic keyed);
		int   high_cycles;
		logic exp_c;
		logic exp_pn;
		high_cycles = 0;
		@(negedge clk48m);
		bus_valid_i = 1'b1;
		bus_req_i   = '{misc_addr(REG_FSEL), wdata, 4'hF};
		#(PERIOD / 4);
		check_value("fsel write ready", 32'(bus_rsp_o.ready), 32'h1);
		@(negedge clk48m);
		bus_valid_i = 1'b0;
		bus_req_i   = '0;
		check_value("fsel_d_o", 32'(fsel_d_o), 32'(wdata[0]));
		for (int n = 1; n <= RELOAD_CYCLES; n++) begin
			@(negedge clk48m);
			exp_c  = (n >= 3) && (n <= 5);
			exp_pn = !(keyed && (n >= 8));
			check_value("fsel_c_o", 32'(fsel_c_o), 32'(exp_c));
			check_value("programn_o", 32'(programn_o), 32'(exp_pn));
			if (fsel_c_o) begin
				high_cycles++;
			end
		end
		check_value("fsel_c_o pulse length", 32'(high_cycles), 32'd3);
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		rst         = 1'b1;
		bus_valid_i = 1'b0;
		bus_req_i   = '0;
		btn_i       = BTN_VALUE;
		genio_in_i  = '0;
		pmod_in_i   = '0;
		checks      = 0;
		errors      = 0;
		rng_state   = 32'd57759;
		fill_table();
		repeat (8) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;
		check_value("programn_o after reset", 32'(programn_o), 32'h1);
		check_value("fsel_c_o after reset", 32'(fsel_c_o), 32'h0);
		check_value("fsel_d_o after reset", 32'(fsel_d_o), 32'h0);
		check_value("led_o after reset", 32'(led_o), 32'h0);
		check_value("irq_o after reset", irq_o, 32'h0);
		check_value("bus ready after reset", 32'(bus_rsp_o.ready), 32'h0);
		check_value("genio_out_o after reset", out_pins(0), 32'h0);
		check_value("genio_oe_o after reset", oe_pins(0), 32'h0);
		check_value("pmod_out_o after reset", out_pins(1), 32'h0);
		check_value("pmod_oe_o after reset", oe_pins(1), 32'h0);

		for (int i = 0; i < N_ENTRIES; i++) begin
			bus_access(table_mem[i], rd, irq_bit);
			if (!table_mem[i].is_write) begin
				check_value($sformatf("rdata entry %0d", i), rd, table_mem[i].exp_rdata);
			end
			check_value($sformatf("irq_o[3] entry %0d", i), 32'(irq_bit),
				32'(table_mem[i].exp_irq));
		end
		check_value("led_o", 32'(led_o), {16'h0, LED_VALUE});

		gpio_bank_test(0);
		gpio_bank_test(1);

		// the keyed write cannot be undone and runs last
		fsel_write_check(32'h0000_0001, 1'b0);
		fsel_write_check({FSEL_KEY, 8'h00}, 1'b1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the bus accesses did not finish in time");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	end

endmodule

//--- src.f
+incdir+.
soc_pkg.sv
bus_ctrl.sv
gpio_bank.sv
scratch_ram.sv
reload_seq.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc_bus -f src.f -o tb_soc_bus

out=$(./obj_dir/tb_soc_bus)
echo "$out"

# fails the script unless the testbench reported a clean run
echo "$out" | grep -qx "No errors"
